// File: source/stage3_pkg.sv
// shared types, exception codes and fixed addresses for the three stage pipeline control
package stage3_pkg;

    typedef logic [31:0] word_t; // data or address word

    localparam word_t RESET_PC    = 32'h0000_0200; // first fetch after reset
    localparam word_t TRAP_VECTOR = 32'h0000_0040; // direct mode only, no vectored table

    // machine exception codes in use
    typedef enum logic [30:0] {
        EX_INSN_MAL     = 31'd0,
        EX_INSN_FAULT   = 31'd1,
        EX_ILLEGAL_INSN = 31'd2,
        EX_BREAKPOINT   = 31'd3,
        EX_L_ADDR_MAL   = 31'd4,
        EX_L_FAULT      = 31'd5,
        EX_S_ADDR_MAL   = 31'd6,
        EX_S_FAULT      = 31'd7,
        EX_ENV_CALL_M   = 31'd11
    } ex_code_t;

    localparam logic [30:0] INT_EXT_CODE = 31'd11; // machine external interrupt

    // mcause word, top bit picks the view
    typedef union packed {
        struct packed {
            logic     interrupt; // always 0 here
            ex_code_t code;
        } ex;
        struct packed {
            logic        interrupt; // always 1 here
            logic [30:0] code;
        } irq;
    } cause_t;

endpackage

// File: source/stage3_hazard_unit_if.sv
// hazard unit interface carrying stage status, stage pcs and pipeline control
interface stage3_hazard_unit_if
    import stage3_pkg::*;
();
    // status from datapath and memories
    logic       i_mem_busy, d_mem_busy;
    logic       dren, dwen, csr_read, reg_write;
    logic [4:0] rs1_e, rs2_e, rd_m;
    logic       jump, branch, mispredict;
    logic       ex_busy, ifence, fence_stall, halt, ret;
    logic       mal_insn, fault_insn, illegal_insn, breakpoint, env;
    logic       mal_l, fault_l, mal_s, fault_s;
    word_t      badaddr;

    // stage pcs, owned by the pc pipeline
    word_t      pc_f, pc_e, pc_m;
    logic       valid_e, valid_m;

    // control out of the hazard unit
    logic       pc_en, npc_sel;
    logic       if_ex_stall, if_ex_flush, ex_mem_stall, ex_mem_flush;
    logic       suppress_iren, suppress_data, rollback;
    logic       insert_priv_pc;
    word_t      priv_pc;

    modport hazard_unit (
        input  i_mem_busy, d_mem_busy, dren, dwen, csr_read, reg_write,
               rs1_e, rs2_e, rd_m, jump, branch, mispredict, ex_busy, ifence,
               fence_stall, halt, ret, mal_insn, fault_insn, illegal_insn,
               breakpoint, env, mal_l, fault_l, mal_s, fault_s, badaddr,
               pc_f, pc_e, pc_m, valid_e, valid_m,
        output pc_en, npc_sel, if_ex_stall, if_ex_flush, ex_mem_stall, ex_mem_flush,
               suppress_iren, suppress_data, rollback, insert_priv_pc, priv_pc
    );

    modport pc_stage (
        input  pc_en, npc_sel, if_ex_stall, if_ex_flush, ex_mem_stall, ex_mem_flush,
               rollback, insert_priv_pc, priv_pc,
        output pc_f, pc_e, pc_m, valid_e, valid_m
    );

    modport top (
        output i_mem_busy, d_mem_busy, dren, dwen, csr_read, reg_write,
               rs1_e, rs2_e, rd_m, jump, branch, mispredict, ex_busy, ifence,
               fence_stall, halt, ret, mal_insn, fault_insn, illegal_insn,
               breakpoint, env, mal_l, fault_l, mal_s, fault_s, badaddr,
        input  pc_en, if_ex_stall, if_ex_flush, ex_mem_stall, ex_mem_flush,
               suppress_iren, suppress_data, pc_f, pc_e, pc_m
    );

endinterface

// File: source/prv_pipeline_if.sv
// link between the hazard unit and the machine trap unit
interface prv_pipeline_if
    import stage3_pkg::*;
();
    // exception flags as seen by the pipeline
    logic  mal_insn, fault_insn, illegal_insn, breakpoint, env;
    logic  mal_l, fault_l, mal_s, fault_s;
    word_t badaddr;  // faulting address for mtval
    word_t epc;      // oldest live pc
    logic  ret;      // mret in flight
    logic  wb_enable;  // pipeline not frozen by halt or fence
    logic  pipe_clear; // no data access outstanding

    // back from the trap unit
    logic  intr;      // enabled interrupt pending
    logic  insert_pc; // redirect fetch now
    word_t priv_pc;

    modport hazard (
        output mal_insn, fault_insn, illegal_insn, breakpoint, env,
               mal_l, fault_l, mal_s, fault_s, badaddr, epc, ret,
               wb_enable, pipe_clear,
        input  intr, insert_pc, priv_pc
    );

    modport prv (
        input  mal_insn, fault_insn, illegal_insn, breakpoint, env,
               mal_l, fault_l, mal_s, fault_s, badaddr, epc, ret,
               wb_enable, pipe_clear,
        output intr, insert_pc, priv_pc
    );

endinterface

// File: source/stage3_hazard_unit.sv
// hazard unit deciding stall, flush, suppression and fetch pc enable for the three stages
module stage3_hazard_unit
    import stage3_pkg::*;
(
    stage3_hazard_unit_if.hazard_unit hazard_if,
    prv_pipeline_if.hazard            prv_pipe_if
);
    logic  rs1_match;
    logic  rs2_match;
    logic  cannot_forward;
    logic  dmem_access;
    logic  branch_jump;
    logic  wait_for_imem;
    logic  wait_for_dmem;
    logic  mem_use_stall;
    logic  exception;
    logic  intr;      // pending interrupt with no exception competing
    logic  intr_go;   // interrupt accepted this cycle
    logic  ex_flush_hazard;
    word_t epc;

    // mem-use detection, x0 never matches
    assign rs1_match      = (hazard_if.rs1_e == hazard_if.rd_m) && (hazard_if.rd_m != 5'd0);
    assign rs2_match      = (hazard_if.rs2_e == hazard_if.rd_m) && (hazard_if.rd_m != 5'd0);
    assign cannot_forward = hazard_if.dren || hazard_if.csr_read; // value only known after M
    assign mem_use_stall  = hazard_if.reg_write && cannot_forward && (rs1_match || rs2_match);

    assign dmem_access   = hazard_if.dren || hazard_if.dwen;
    assign branch_jump   = hazard_if.jump || (hazard_if.branch && hazard_if.mispredict);
    assign wait_for_imem = hazard_if.i_mem_busy && !hazard_if.suppress_iren;
    assign wait_for_dmem = dmem_access && hazard_if.d_mem_busy && !hazard_if.suppress_data;

    assign hazard_if.npc_sel = branch_jump; // resolved target from E

    // trap side
    assign exception = hazard_if.mal_insn | hazard_if.fault_insn | hazard_if.illegal_insn
                     | hazard_if.breakpoint | hazard_if.env
                     | hazard_if.mal_l | hazard_if.fault_l
                     | hazard_if.mal_s | hazard_if.fault_s;
    assign intr = !exception && prv_pipe_if.intr;

    assign prv_pipe_if.pipe_clear = !wait_for_dmem;   // let an outstanding load/store land
    assign prv_pipe_if.wb_enable  = !hazard_if.halt && !hazard_if.fence_stall;
    assign intr_go = intr && prv_pipe_if.pipe_clear && prv_pipe_if.wb_enable; // matches trap unit

    assign hazard_if.rollback = hazard_if.ifence && !hazard_if.fence_stall; // refetch after fence
    assign ex_flush_hazard = exception || intr_go || hazard_if.ret || hazard_if.rollback;

    assign hazard_if.insert_priv_pc = prv_pipe_if.insert_pc;
    assign hazard_if.priv_pc        = prv_pipe_if.priv_pc;

    // no new fetch request when the stream is about to be thrown away
    assign hazard_if.suppress_iren = branch_jump || ex_flush_hazard || prv_pipe_if.insert_pc;
    assign hazard_if.suppress_data = exception; // keep the faulting access off the bus

    // oldest live instruction, an interrupt lets the M op finish
    assign epc = (hazard_if.valid_m && (!intr || branch_jump)) ? hazard_if.pc_m
               : (hazard_if.valid_e ? hazard_if.pc_e : hazard_if.pc_f);

    assign prv_pipe_if.mal_insn     = hazard_if.mal_insn;
    assign prv_pipe_if.fault_insn   = hazard_if.fault_insn;
    assign prv_pipe_if.illegal_insn = hazard_if.illegal_insn;
    assign prv_pipe_if.breakpoint   = hazard_if.breakpoint;
    assign prv_pipe_if.env          = hazard_if.env;
    assign prv_pipe_if.mal_l        = hazard_if.mal_l;
    assign prv_pipe_if.fault_l      = hazard_if.fault_l;
    assign prv_pipe_if.mal_s        = hazard_if.mal_s;
    assign prv_pipe_if.fault_s      = hazard_if.fault_s;
    assign prv_pipe_if.badaddr      = hazard_if.badaddr;
    assign prv_pipe_if.epc          = epc;
    assign prv_pipe_if.ret          = hazard_if.ret;

    // pc moves when F can hand over, or on any redirect
    assign hazard_if.pc_en = (!hazard_if.if_ex_stall && !wait_for_imem)
                           || branch_jump
                           || ex_flush_hazard
                           || prv_pipe_if.insert_pc;

    // bubble into E on redirect, or when fetch lags behind moving E/M
    assign hazard_if.if_ex_flush = ex_flush_hazard
                                 || branch_jump
                                 || (wait_for_imem && !hazard_if.ex_mem_stall);

    // bubble into M on redirect, or when E holds but M drains
    assign hazard_if.ex_mem_flush = ex_flush_hazard
                                  || branch_jump
                                  || (hazard_if.if_ex_stall && !hazard_if.ex_mem_stall);

    // M stall implies E stall
    // a busy E gives way to a redirect, otherwise it keeps its insn
    assign hazard_if.if_ex_stall = hazard_if.ex_mem_stall
                                 || (hazard_if.ex_busy && !ex_flush_hazard && !branch_jump)
                                 || mem_use_stall
                                 || hazard_if.fence_stall;

    assign hazard_if.ex_mem_stall = wait_for_dmem
                                  || hazard_if.fence_stall
                                  || hazard_if.halt; // freeze everything

endmodule

// File: source/stage3_pc_pipeline.sv
// fetch pc register with next pc select, plus pc and valid tracking for execute and memory
module stage3_pc_pipeline
    import stage3_pkg::*;
(
    input  logic  CLK,
    input  logic  rst,
    input  word_t branch_target,              // resolved jump/branch target from E
    stage3_hazard_unit_if.pc_stage hazard_if
);
    word_t npc;

    // redirect priority, trap/ret first
    always_comb begin
        if (hazard_if.insert_priv_pc) begin
            npc = hazard_if.priv_pc;
        end else if (hazard_if.npc_sel) begin
            npc = branch_target;
        end else if (hazard_if.rollback) begin
            npc = hazard_if.pc_e + 32'd4; // insn right after the fence
        end else begin
            npc = hazard_if.pc_f + 32'd4;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            hazard_if.pc_f <= RESET_PC;
        end else if (hazard_if.pc_en) begin
            hazard_if.pc_f <= npc;
        end // else hold
    end

    // F -> E, flush wins over stall
    always_ff @(posedge CLK) begin
        if (rst) begin
            hazard_if.valid_e <= 1'b0;
        end else if (hazard_if.if_ex_flush) begin
            hazard_if.valid_e <= 1'b0;
        end else if (!hazard_if.if_ex_stall) begin
            hazard_if.valid_e <= 1'b1; // fetch always offers an insn
        end
    end

    always_ff @(posedge CLK) begin
        if (!hazard_if.if_ex_stall) begin
            hazard_if.pc_e <= hazard_if.pc_f;
        end
    end

    // E -> M
    always_ff @(posedge CLK) begin
        if (rst) begin
            hazard_if.valid_m <= 1'b0;
        end else if (hazard_if.ex_mem_flush) begin
            hazard_if.valid_m <= 1'b0;
        end else if (!hazard_if.ex_mem_stall) begin
            hazard_if.valid_m <= hazard_if.valid_e;
        end
    end

    always_ff @(posedge CLK) begin
        if (!hazard_if.ex_mem_stall) begin
            hazard_if.pc_m <= hazard_if.pc_e;
        end
    end

endmodule

// File: source/stage3_trap_unit.sv
// machine trap unit ranking causes, gating the external interrupt and holding mepc, mcause, mtval
module stage3_trap_unit
    import stage3_pkg::*;
(
    input  logic   CLK,
    input  logic   rst,
    input  logic   ext_irq,
    output word_t  mepc,
    output word_t  mtval,
    output cause_t mcause,
    output logic   trap_taken,   // one cycle after entry
    prv_pipeline_if.prv prv_pipe_if
);
    logic     exception;
    logic     int_take;
    logic     trap_entry;
    logic     mie;       // global interrupt enable
    logic     mpie;      // enable saved on entry
    ex_code_t ex_code;
    cause_t   next_cause;

    assign exception = prv_pipe_if.mal_insn | prv_pipe_if.fault_insn | prv_pipe_if.illegal_insn
                     | prv_pipe_if.breakpoint | prv_pipe_if.env
                     | prv_pipe_if.mal_l | prv_pipe_if.fault_l
                     | prv_pipe_if.mal_s | prv_pipe_if.fault_s;

    assign prv_pipe_if.intr = ext_irq && mie;
    // interrupt only once data side is quiet and pipe not frozen
    assign int_take = prv_pipe_if.intr && !exception
                   && prv_pipe_if.pipe_clear && prv_pipe_if.wb_enable;
    assign trap_entry = exception || int_take;

    assign prv_pipe_if.insert_pc = trap_entry || prv_pipe_if.ret;
    assign prv_pipe_if.priv_pc   = trap_entry ? TRAP_VECTOR : mepc; // entry beats mret

    // fetch side first, then decode, then memory side
    always_comb begin
        if (prv_pipe_if.mal_insn) begin
            ex_code = EX_INSN_MAL;
        end else if (prv_pipe_if.fault_insn) begin
            ex_code = EX_INSN_FAULT;
        end else if (prv_pipe_if.illegal_insn) begin
            ex_code = EX_ILLEGAL_INSN;
        end else if (prv_pipe_if.breakpoint) begin
            ex_code = EX_BREAKPOINT;
        end else if (prv_pipe_if.env) begin
            ex_code = EX_ENV_CALL_M;
        end else if (prv_pipe_if.mal_l) begin
            ex_code = EX_L_ADDR_MAL;
        end else if (prv_pipe_if.fault_l) begin
            ex_code = EX_L_FAULT;
        end else if (prv_pipe_if.mal_s) begin
            ex_code = EX_S_ADDR_MAL;
        end else begin
            ex_code = EX_S_FAULT; // lowest rank
        end
    end

    always_comb begin
        next_cause = '0;
        if (exception) begin
            next_cause.ex.interrupt = 1'b0;
            next_cause.ex.code      = ex_code;
        end else begin
            next_cause.irq.interrupt = 1'b1;
            next_cause.irq.code      = INT_EXT_CODE;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            mepc       <= '0;
            mcause     <= '0;
            mtval      <= '0;
            trap_taken <= 1'b0;
            mie        <= 1'b1;
            mpie       <= 1'b0;
        end else begin
            trap_taken <= trap_entry;
            if (trap_entry) begin
                mepc   <= prv_pipe_if.epc;
                mcause <= next_cause;
                mtval  <= exception ? prv_pipe_if.badaddr : '0; // no address for irq
                mpie   <= mie;
                mie    <= 1'b0; // mask nested irqs
            end else if (prv_pipe_if.ret) begin
                mie  <= mpie;
                mpie <= 1'b1;
            end
        end
    end

endmodule

// File: source/stage3_control.sv
// pipeline control top tying hazard unit, pc pipeline and trap unit to plain status ports
module stage3_control
    import stage3_pkg::*;
(
    input  logic       CLK,
    input  logic       rst,
    input  logic       ext_irq,
    input  logic       i_mem_busy, d_mem_busy,
    input  logic       dren, dwen, csr_read, reg_write,
    input  logic [4:0] rs1_e, rs2_e, rd_m,
    input  logic       jump, branch, mispredict,
    input  logic       ex_busy, ifence, fence_stall, halt, ret,
    input  logic       mal_insn, fault_insn, illegal_insn, breakpoint, env,
    input  logic       mal_l, fault_l, mal_s, fault_s,
    input  word_t      badaddr,
    input  word_t      branch_target,
    output word_t      pc_f,
    output logic       pc_en,
    output logic       if_ex_stall, if_ex_flush,
    output logic       ex_mem_stall, ex_mem_flush,
    output logic       suppress_iren, suppress_data,
    output word_t      mepc,
    output cause_t     mcause,
    output word_t      mtval,
    output logic       trap_taken
);
    stage3_hazard_unit_if hazard_if ();
    prv_pipeline_if       prv_pipe_if ();

    // status into the shared bundle
    assign hazard_if.i_mem_busy   = i_mem_busy;
    assign hazard_if.d_mem_busy   = d_mem_busy;
    assign hazard_if.dren         = dren;
    assign hazard_if.dwen         = dwen;
    assign hazard_if.csr_read     = csr_read;
    assign hazard_if.reg_write    = reg_write;
    assign hazard_if.rs1_e        = rs1_e;
    assign hazard_if.rs2_e        = rs2_e;
    assign hazard_if.rd_m         = rd_m;
    assign hazard_if.jump         = jump;
    assign hazard_if.branch       = branch;
    assign hazard_if.mispredict   = mispredict;
    assign hazard_if.ex_busy      = ex_busy;
    assign hazard_if.ifence       = ifence;
    assign hazard_if.fence_stall  = fence_stall;
    assign hazard_if.halt         = halt;
    assign hazard_if.ret          = ret;
    assign hazard_if.mal_insn     = mal_insn;
    assign hazard_if.fault_insn   = fault_insn;
    assign hazard_if.illegal_insn = illegal_insn;
    assign hazard_if.breakpoint   = breakpoint;
    assign hazard_if.env          = env;
    assign hazard_if.mal_l        = mal_l;
    assign hazard_if.fault_l      = fault_l;
    assign hazard_if.mal_s        = mal_s;
    assign hazard_if.fault_s      = fault_s;
    assign hazard_if.badaddr      = badaddr;

    // control back out
    assign pc_f          = hazard_if.pc_f;
    assign pc_en         = hazard_if.pc_en;
    assign if_ex_stall   = hazard_if.if_ex_stall;
    assign if_ex_flush   = hazard_if.if_ex_flush;
    assign ex_mem_stall  = hazard_if.ex_mem_stall;
    assign ex_mem_flush  = hazard_if.ex_mem_flush;
    assign suppress_iren = hazard_if.suppress_iren;
    assign suppress_data = hazard_if.suppress_data;

    stage3_hazard_unit hazard_unit_inst (
        .hazard_if   (hazard_if),
        .prv_pipe_if (prv_pipe_if)
    );

    stage3_pc_pipeline pc_pipeline_inst (
        .CLK           (CLK),
        .rst           (rst),
        .branch_target (branch_target),
        .hazard_if     (hazard_if)
    );

    stage3_trap_unit trap_unit_inst (
        .CLK         (CLK),
        .rst         (rst),
        .ext_irq     (ext_irq),
        .mepc        (mepc),
        .mtval       (mtval),
        .mcause      (mcause),
        .trap_taken  (trap_taken),
        .prv_pipe_if (prv_pipe_if)
    );

endmodule

// File: dv/tb_clock_gen.sv
// free running testbench clock, period 8
module tb_clock_gen (
    output logic clk
);
    localparam int HALF_PERIOD = 4;

    initial begin
        clk = 1'b0; // first rising edge at 4
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

// File: dv/stage3_control_tb.sv
// table driven testbench for the pipeline control top with a reference model of pc and traps
module stage3_control_tb
    import stage3_pkg::*;
();
    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 10;
    localparam int SEED         = 67432;

    // stimulus bits, one per status input
    localparam logic [20:0] IDLE    = 21'd0;
    localparam logic [20:0] IRQ     = 21'd1 << 0;
    localparam logic [20:0] IBUSY   = 21'd1 << 1;
    localparam logic [20:0] DBUSY   = 21'd1 << 2;
    localparam logic [20:0] DREN    = 21'd1 << 3;
    localparam logic [20:0] DWEN    = 21'd1 << 4;
    localparam logic [20:0] CSRR    = 21'd1 << 5;
    localparam logic [20:0] REGW    = 21'd1 << 6;
    localparam logic [20:0] JUMP    = 21'd1 << 7;
    localparam logic [20:0] BRANCH  = 21'd1 << 8;
    localparam logic [20:0] MISPRED = 21'd1 << 9;
    localparam logic [20:0] EXBUSY  = 21'd1 << 10;
    localparam logic [20:0] RET     = 21'd1 << 11;
    localparam logic [20:0] MAL_I   = 21'd1 << 12;
    localparam logic [20:0] FAULT_I = 21'd1 << 13;
    localparam logic [20:0] ILLEGAL = 21'd1 << 14;
    localparam logic [20:0] BRKPT   = 21'd1 << 15;
    localparam logic [20:0] ENV     = 21'd1 << 16;
    localparam logic [20:0] MAL_L   = 21'd1 << 17;
    localparam logic [20:0] FAULT_L = 21'd1 << 18;
    localparam logic [20:0] MAL_S   = 21'd1 << 19;
    localparam logic [20:0] FAULT_S = 21'd1 << 20;
    localparam logic [20:0] EXC_ALL = 21'h1ff000; // all nine exception flags

    // expected control bits: pc_en, if_ex_stall, if_ex_flush, ex_mem_stall,
    // ex_mem_flush, suppress_iren, suppress_data
    localparam logic [6:0] RUN      = 7'b1000000;
    localparam logic [6:0] HOLD_E   = 7'b0100100; // E holds, bubble into M
    localparam logic [6:0] DWAIT    = 7'b0101000; // whole pipe frozen
    localparam logic [6:0] IWAIT    = 7'b0010000; // bubble into E, F holds
    localparam logic [6:0] REDIRECT = 7'b1010110;
    localparam logic [6:0] TRAP_EXC = 7'b1010111;

    // register pairing for the hazard rows
    localparam logic [1:0] RD_ANY   = 2'd0;
    localparam logic [1:0] RD_MATCH = 2'd1;
    localparam logic [1:0] RD_ZERO  = 2'd2;

    logic       clk, rst, ext_irq, i_mem_busy, d_mem_busy;
    logic       dren, dwen, csr_read, reg_write;
    logic [4:0] rs1_e, rs2_e, rd_m;
    logic       jump, branch, mispredict, ex_busy, ifence, fence_stall, halt, ret;
    logic       mal_insn, fault_insn, illegal_insn, breakpoint, env;
    logic       mal_l, fault_l, mal_s, fault_s;
    word_t      badaddr, branch_target, pc_f, mepc, mtval;
    cause_t     mcause;
    logic       pc_en, if_ex_stall, if_ex_flush, ex_mem_stall, ex_mem_flush;
    logic       suppress_iren, suppress_data, trap_taken;

    logic [20:0] stim_q[$];
    logic [1:0]  rd_q[$];
    logic [6:0]  exp_q[$];
    int          row_idx, error_count, cycle_count, cycle_limit, seed_val;

    // reference state
    word_t       m_pc_f, m_pc_e, m_pc_m, m_mepc, m_mtval;
    logic [31:0] m_mcause;
    logic        m_valid_e, m_valid_m, m_taken, m_mie, m_mpie;

    tb_clock_gen clock_gen_inst (.clk(clk));

    stage3_control stage3_control_inst (.CLK(clk), .*);

    task automatic add_row(input logic [20:0] s, input logic [1:0] rd_mode,
                           input logic [6:0] ctl);
        stim_q.push_back(s);
        rd_q.push_back(rd_mode);
        exp_q.push_back(ctl);
    endtask

    task automatic drive_row(input logic [20:0] s, input logic [1:0] rd_mode);
        logic [4:0] r;
        r = 5'($urandom_range(31, 1)); // nonzero register
        {fault_s, mal_s, fault_l, mal_l, env, breakpoint, illegal_insn, fault_insn, mal_insn,
         ret, ex_busy, mispredict, branch, jump, reg_write, csr_read, dwen, dren,
         d_mem_busy, i_mem_busy, ext_irq} = s;
        rd_m          = (rd_mode == RD_ZERO) ? 5'd0 : r;
        rs1_e         = (rd_mode == RD_ANY) ? 5'($urandom) : rd_m; // hazard rows pair rs1 with rd
        rs2_e         = 5'($urandom);
        badaddr       = $urandom;
        branch_target = $urandom & 32'hffff_fffc; // word aligned
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        error_count++;
        $display("Mismatch %s: got 0x%08h expected 0x%08h at row %0d", name, got, exp, row_idx);
    endtask

    // fetch side first, then decode, then memory side
    function automatic logic [30:0] ranked_exception_code(input logic [20:0] s);
        if (|(s & MAL_I))        return 31'd0;
        else if (|(s & FAULT_I)) return 31'd1;
        else if (|(s & ILLEGAL)) return 31'd2;
        else if (|(s & BRKPT))   return 31'd3;
        else if (|(s & ENV))     return 31'd11; // ecall from M
        else if (|(s & MAL_L))   return 31'd4;
        else if (|(s & FAULT_L)) return 31'd5;
        else if (|(s & MAL_S))   return 31'd6;
        else                     return 31'd7;
    endfunction

    // one rising edge of the reference pipeline and trap state
    task automatic update_model(input logic [20:0] s, input logic [6:0] ctl);
        logic  exc, irq_pend, take_irq, redirect, trap;
        word_t epc, npc;
        exc      = |(s & EXC_ALL);
        irq_pend = |(s & IRQ) && m_mie && !exc;
        take_irq = irq_pend && !(|(s & (DREN | DWEN)) && |(s & DBUSY)); // waits for data side
        redirect = |(s & JUMP) || (|(s & BRANCH) && |(s & MISPRED));
        trap     = exc || take_irq;
        epc = (m_valid_m && (!irq_pend || redirect)) ? m_pc_m : (m_valid_e ? m_pc_e : m_pc_f);
        if (trap) npc = TRAP_VECTOR;
        else if (|(s & RET)) npc = m_mepc;
        else if (redirect) npc = branch_target;
        else npc = m_pc_f + 32'd4;
        // M before E before F, old values move down
        if (!ctl[3]) m_pc_m = m_pc_e;
        if (ctl[2]) m_valid_m = 1'b0;
        else if (!ctl[3]) m_valid_m = m_valid_e;
        if (ctl[4]) m_valid_e = 1'b0;
        else if (!ctl[5]) m_valid_e = 1'b1;
        if (!ctl[5]) m_pc_e = m_pc_f;
        if (ctl[6]) m_pc_f = npc;
        m_taken = trap;
        if (trap) begin
            m_mepc   = epc;
            m_mcause = exc ? {1'b0, ranked_exception_code(s)} : {1'b1, 31'd11};
            m_mtval  = exc ? badaddr : 32'd0;
            m_mpie   = m_mie;
            m_mie    = 1'b0;
        end else if (|(s & RET)) begin
            m_mie  = m_mpie;
            m_mpie = 1'b1;
        end
    endtask

    // run limit, four cycles a row plus reset
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: table not finished after %0d cycles", cycle_count);
            $display("rows %0d, errors %0d", row_idx, error_count);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        seed_val = $urandom(SEED);
        error_count = 0;
        cycle_count = 0;
        rst = 1'b1;
        ifence = 1'b0;
        fence_stall = 1'b0;
        halt = 1'b0;
        drive_row(IDLE, RD_ANY);
        repeat (3) add_row(IDLE, RD_ANY, RUN);           // fill E and M
        add_row(DREN | REGW, RD_MATCH, HOLD_E);          // load-use
        add_row(DREN | REGW, RD_ZERO, RUN);              // x0 never stalls
        add_row(CSRR | REGW, RD_MATCH, HOLD_E);
        add_row(DREN | DBUSY, RD_ANY, DWAIT);
        add_row(DWEN | DBUSY, RD_ANY, DWAIT);
        add_row(DREN, RD_ANY, RUN);                      // busy drops, pc + 4
        add_row(BRANCH | MISPRED, RD_ANY, REDIRECT);
        add_row(BRANCH, RD_ANY, RUN);                    // predicted right, fetch runs on
        add_row(JUMP | EXBUSY, RD_ANY, REDIRECT);        // busy E yields
        add_row(EXBUSY, RD_ANY, HOLD_E);
        repeat (2) add_row(IDLE, RD_ANY, RUN);
        add_row(ILLEGAL | MAL_L | FAULT_S, RD_ANY, TRAP_EXC);
        add_row(RET, RD_ANY, REDIRECT);
        add_row(BRKPT | ENV | MAL_S, RD_ANY, TRAP_EXC);
        add_row(RET, RD_ANY, REDIRECT);
        add_row(ENV | FAULT_L | DREN | DBUSY, RD_ANY, TRAP_EXC); // faulting access not waited on
        add_row(RET, RD_ANY, REDIRECT);
        add_row(MAL_I | FAULT_I | FAULT_S, RD_ANY, TRAP_EXC);
        add_row(RET, RD_ANY, REDIRECT);
        repeat (2) add_row(IDLE, RD_ANY, RUN);
        repeat (2) add_row(IRQ | DREN | DBUSY, RD_ANY, DWAIT); // irq held off
        add_row(IRQ | DREN, RD_ANY, REDIRECT);           // taken once data side is quiet
        add_row(IRQ, RD_ANY, RUN);                       // masked until mret
        add_row(RET, RD_ANY, REDIRECT);
        add_row(IDLE, RD_ANY, RUN);
        repeat (2) add_row(IBUSY, RD_ANY, IWAIT);
        add_row(IDLE, RD_ANY, RUN);
        add_row(IBUSY | BRANCH | MISPRED, RD_ANY, REDIRECT); // fetch dropped, no wait
        add_row(IDLE, RD_ANY, RUN);
        cycle_limit = stim_q.size() * 4 + RESET_CYCLES;

        // state right after reset
        m_pc_f = RESET_PC;
        m_pc_e = RESET_PC;
        m_pc_m = RESET_PC;
        m_valid_e = 1'b0;
        m_valid_m = 1'b0;
        m_mepc = '0;
        m_mtval = '0;
        m_mcause = '0;
        m_taken = 1'b0;
        m_mie = 1'b1;
        m_mpie = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (row_idx = 0; row_idx < stim_q.size(); row_idx++) begin
            drive_row(stim_q[row_idx], rd_q[row_idx]);
            #(HALF_PERIOD - 1); // just before the rising edge
            if (pc_en !== exp_q[row_idx][6]) report_mismatch("pc_en", pc_en, exp_q[row_idx][6]);
            if (if_ex_stall !== exp_q[row_idx][5])
                report_mismatch("if_ex_stall", if_ex_stall, exp_q[row_idx][5]);
            if (if_ex_flush !== exp_q[row_idx][4])
                report_mismatch("if_ex_flush", if_ex_flush, exp_q[row_idx][4]);
            if (ex_mem_stall !== exp_q[row_idx][3])
                report_mismatch("ex_mem_stall", ex_mem_stall, exp_q[row_idx][3]);
            if (ex_mem_flush !== exp_q[row_idx][2])
                report_mismatch("ex_mem_flush", ex_mem_flush, exp_q[row_idx][2]);
            if (suppress_iren !== exp_q[row_idx][1])
                report_mismatch("suppress_iren", suppress_iren, exp_q[row_idx][1]);
            if (suppress_data !== exp_q[row_idx][0])
                report_mismatch("suppress_data", suppress_data, exp_q[row_idx][0]);
            update_model(stim_q[row_idx], exp_q[row_idx]);
            @(posedge clk);
            #1;
            if (pc_f !== m_pc_f) report_mismatch("pc_f", pc_f, m_pc_f);
            if (mepc !== m_mepc) report_mismatch("mepc", mepc, m_mepc);
            if (mtval !== m_mtval) report_mismatch("mtval", mtval, m_mtval);
            if (trap_taken !== m_taken) report_mismatch("trap_taken", trap_taken, m_taken);
            if (mcause[31] !== m_mcause[31])
                report_mismatch("mcause.interrupt", mcause[31], m_mcause[31]);
            // top bit picks how the code is read
            if (mcause.irq.interrupt && (mcause.irq.code !== m_mcause[30:0]))
                report_mismatch("mcause.irq.code", mcause.irq.code, m_mcause[30:0]);
            if (!mcause.ex.interrupt && (mcause.ex.code !== m_mcause[30:0]))
                report_mismatch("mcause.ex.code", mcause.ex.code, m_mcause[30:0]);
            @(negedge clk);
        end

        $display("rows %0d, errors %0d", stim_q.size(), error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: stage3_control.f
source/stage3_pkg.sv
source/stage3_hazard_unit_if.sv
source/prv_pipeline_if.sv
source/stage3_hazard_unit.sv
source/stage3_pc_pipeline.sv
source/stage3_trap_unit.sv
source/stage3_control.sv
dv/tb_clock_gen.sv
dv/stage3_control_tb.sv

// File: Makefile
TOOL     = verilator
TOP      = stage3_control_tb
FILELIST = stage3_control.f
FLAGS    = --binary --timing -j 0
BUILD    = obj_dir
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
